//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP      := tb_route_table
FILELIST := files.f
BUILD    := obj_dir
LOG      := sim.log

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard verif/*.svh)
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- files.f
+incdir+verif
source/xb_geom_pkg.sv
source/route_table_pkg.sv
source/insert_capture.sv
source/insert_mux.sv
source/slot_counter.sv
source/kv_store.sv
source/route_fsm.sv
source/route_table_top.sv
verif/tb_route_table.sv

//--- source/insert_capture.sv
// --------------------------------------
// Holds one insert at a time, strobes while full are dropped
// --------------------------------------
`timescale 1ns/1ns
`default_nettype none

module insert_capture
  import xb_geom_pkg::*;
(
  input  wire                   clk,
  input  wire                   reset,
  input  wire                   req_wr,
  input  wire  [epid_w-1:0]     req_addr,
  input  wire  [req_data_w-1:0] req_data,
  output logic                  held_valid,
  output logic [epid_w-1:0]     held_epid,
  output logic [port_w-1:0]     held_port,
  input  wire                   take,
  output logic                  resp_ack
);

  // Occupancy flag, set by a strobe while empty
  always_ff @(posedge clk) begin
    if (reset) begin
      held_valid <= 1'b0;
    end else if (!held_valid && req_wr) begin
      held_valid <= 1'b1;
    end else if (take) begin
      held_valid <= 1'b0;
    end
  end

  // Only the low bits of the request data carry the port number
  always_ff @(posedge clk) begin
    if (!held_valid && req_wr) begin
      held_epid <= req_addr;
      held_port <= req_data[port_w-1:0];
    end
  end

  // Ack in the cycle the mux accepts the item
  assign resp_ack = take && held_valid;

  // Mux must only take from a loaded register
  take_needs_item: assert property (@(posedge clk) disable iff (reset) take |-> held_valid)
    else $error("insert_capture taken while empty");

endmodule

`default_nettype wire

//--- source/insert_mux.sv
// --------------------------------------
// One item per cycle, priority rotates past the last winner
// --------------------------------------
`timescale 1ns/1ns
`default_nettype none

module insert_mux
  import xb_geom_pkg::*;
(
  input  wire                         clk,
  input  wire                         reset,
  input  wire  [cfg_ports-1:0]        src_valid,
  input  wire  [cfg_ports*epid_w-1:0] src_epid,
  input  wire  [cfg_ports*port_w-1:0] src_port,
  output logic [cfg_ports-1:0]        src_take,
  output logic                        ins_valid,
  output logic [epid_w-1:0]           ins_epid,
  output logic [port_w-1:0]           ins_port,
  input  wire                         ins_ready
);

  logic [cfg_sel_w-1:0] last_grant;
  logic [cfg_sel_w-1:0] grant_idx;
  logic                 grant_any;
  logic                 can_load;

  // Output register empty or draining this cycle
  assign can_load = !ins_valid || ins_ready;

  // ------------------------------------
  // Round-robin pick
  // ------------------------------------
  always_comb begin
    int cand;
    grant_any = 1'b0;
    grant_idx = last_grant;
    src_take  = '0;
    // Scan starts one past the last winner
    for (int off = 1; off <= cfg_ports; off++) begin
      cand = (int'(last_grant) + off) % cfg_ports;
      if (!grant_any && src_valid[cand]) begin
        grant_any = 1'b1;
        grant_idx = cfg_sel_w'(cand);
      end
    end
    if (grant_any && can_load) begin
      src_take[grant_idx] = 1'b1;
    end
  end

  // Valid flag and pointer, pointer moves only on a real grant
  always_ff @(posedge clk) begin
    if (reset) begin
      ins_valid  <= 1'b0;
      last_grant <= cfg_sel_w'(cfg_ports - 1);
    end else if (can_load) begin
      ins_valid <= grant_any;
      if (grant_any) begin
        last_grant <= grant_idx;
      end
    end
  end

  // Copy of the winning item
  always_ff @(posedge clk) begin
    if (can_load && grant_any) begin
      ins_epid <= src_epid[grant_idx*epid_w +: epid_w];
      ins_port <= src_port[grant_idx*port_w +: port_w];
    end
  end

  // Sources keep their item until it is taken
  src_hold: assert property (@(posedge clk) disable iff (reset)
    (src_valid & ~src_take) != '0 |=> ($past(src_valid & ~src_take) & ~src_valid) == '0)
    else $error("insert_mux source dropped an item before it was taken");

  // Controller drains only a loaded output register
  ins_drain_valid: assert property (@(posedge clk) disable iff (reset)
    ins_ready |-> ins_valid)
    else $error("insert_mux output drained while empty");

endmodule

`default_nettype wire

//--- source/kv_store.sv
// --------------------------------------
// Lowest matching slot wins if a key is stored twice
// --------------------------------------
`timescale 1ns/1ns
`default_nettype none

module kv_store
  import xb_geom_pkg::*;
  import route_table_pkg::*;
(
  input  wire               clk,
  input  wire               reset,
  input  wire  [epid_w-1:0] match_key,
  output logic              match_hit,
  output logic [slot_w-1:0] match_slot,
  output logic [port_w-1:0] match_port,
  input  wire               wr_en,
  input  wire  [slot_w-1:0] wr_slot,
  input  wire  [epid_w-1:0] wr_key,
  input  wire  [port_w-1:0] wr_port
);

  logic [table_depth-1:0] ent_valid;
  logic [epid_w-1:0]      ent_key  [table_depth];
  logic [port_w-1:0]      ent_port [table_depth];

  // Parallel compare, scanned downward so the lowest hit sticks
  always_comb begin
    match_hit  = 1'b0;
    match_slot = '0;
    for (int i = table_depth - 1; i >= 0; i--) begin
      if (ent_valid[i] && ent_key[i] == match_key) begin
        match_hit  = 1'b1;
        match_slot = slot_w'(i);
      end
    end
  end

  // Value read, meaningless on a miss
  assign match_port = ent_port[match_slot];

  always_ff @(posedge clk) begin
    if (reset) begin
      ent_valid <= '0;
    end else if (wr_en) begin
      ent_valid[wr_slot] <= 1'b1;
    end
  end

  // Key and value storage
  always_ff @(posedge clk) begin
    if (wr_en) begin
      ent_key[wr_slot]  <= wr_key;
      ent_port[wr_slot] <= wr_port;
    end
  end

endmodule

`default_nettype wire

//--- source/route_fsm.sv
// --------------------------------------
// Inserts beat finds, one table access every other cycle at most
// --------------------------------------
`timescale 1ns/1ns
`default_nettype none

module route_fsm
  import xb_geom_pkg::*;
  import route_table_pkg::*;
(
  input  wire                         clk,
  input  wire                         reset,
  input  wire                         ins_valid,
  input  wire  [epid_w-1:0]           ins_epid,
  input  wire  [port_w-1:0]           ins_port,
  output logic                        ins_ready,
  input  wire  [num_ports*epid_w-1:0] find_tdata,
  input  wire  [num_ports-1:0]        find_tvalid,
  output logic [num_ports-1:0]        find_tready,
  output logic [num_ports*port_w-1:0] result_tdata,
  output logic [num_ports-1:0]        result_tkeep,
  output logic [num_ports-1:0]        result_tvalid,
  input  wire  [num_ports-1:0]        result_tready,
  output logic [epid_w-1:0]           match_key,
  input  wire                         match_hit,
  input  wire  [slot_w-1:0]           match_slot,
  input  wire  [port_w-1:0]           match_port,
  output logic                        wr_en,
  output logic [slot_w-1:0]           wr_slot,
  output logic [epid_w-1:0]           wr_key,
  output logic [port_w-1:0]           wr_port,
  output logic                        claim,
  input  wire  [slot_w-1:0]           next_slot,
  input  wire                         full
);

  logic [1:0]        state;
  logic [epid_w-1:0] ins_key_q;
  logic [port_w-1:0] ins_port_q;
  logic [epid_w-1:0] find_key_q;
  logic [port_w-1:0] find_sel_q;
  logic [port_w-1:0] last_find;
  logic [port_w-1:0] find_idx;
  logic              find_any;

  // ------------------------------------
  // Find arbitration
  // ------------------------------------
  // Only ports with an empty result register compete
  always_comb begin
    int cand;
    find_any = 1'b0;
    find_idx = last_find;
    for (int off = 1; off <= num_ports; off++) begin
      cand = (int'(last_find) + off) % num_ports;
      if (!find_any && find_tvalid[cand] && !result_tvalid[cand]) begin
        find_any = 1'b1;
        find_idx = port_w'(cand);
      end
    end
  end

  // Shared match port follows the state
  assign match_key = (state == st_insert) ? ins_key_q : find_key_q;
  assign wr_key    = ins_key_q;
  assign wr_port   = ins_port_q;

  always_comb begin
    ins_ready   = 1'b0;
    find_tready = '0;
    wr_en       = 1'b0;
    wr_slot     = match_slot;
    claim       = 1'b0;
    case (state)
      st_idle: begin
        if (ins_valid) begin
          ins_ready = 1'b1;
        end else if (find_any) begin
          find_tready[find_idx] = 1'b1;
        end
      end
      st_insert: begin
        // Hit overwrites in place, miss appends, full drops
        if (match_hit) begin
          wr_en = 1'b1;
        end else if (!full) begin
          wr_en   = 1'b1;
          wr_slot = next_slot;
          claim   = 1'b1;
        end
      end
      default: begin
      end
    endcase
  end

  // ------------------------------------
  // State, pointer and result flags
  // ------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state         <= st_idle;
      last_find     <= port_w'(num_ports - 1);
      result_tvalid <= '0;
    end else begin
      result_tvalid <= result_tvalid & ~result_tready;
      case (state)
        st_idle: begin
          if (ins_valid) begin
            state <= st_insert;
          end else if (find_any) begin
            state     <= st_find;
            last_find <= find_idx;
          end
        end
        st_insert: state <= st_idle;
        st_find: begin
          // Selected port was empty when granted
          result_tvalid[find_sel_q] <= 1'b1;
          state                     <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Captured keys and result payload
  always_ff @(posedge clk) begin
    if (ins_ready) begin
      ins_key_q  <= ins_epid;
      ins_port_q <= ins_port;
    end
    if (|find_tready) begin
      find_key_q <= find_tdata[find_idx*epid_w +: epid_w];
      find_sel_q <= find_idx;
    end
    if (state == st_find) begin
      result_tdata[find_sel_q*port_w +: port_w] <= match_hit ? match_port : '0;
      result_tkeep[find_sel_q]                  <= match_hit;
    end
  end

endmodule

`default_nettype wire

//--- source/route_table_pkg.sv
// --------------------------------------
// Table depth must stay a power of two matching slot_w
// --------------------------------------
`default_nettype none

package route_table_pkg;

  // Entry count and entry index width
  localparam int table_depth = 16;
  localparam int slot_w      = 4;

  // ------------------------------------
  // Route controller states
  // ------------------------------------
  localparam logic [1:0] st_idle   = 2'd0;
  localparam logic [1:0] st_insert = 2'd1;
  localparam logic [1:0] st_find   = 2'd2;

endpackage

`default_nettype wire

//--- source/route_table_top.sv
// --------------------------------------
// Fixed four-port table, the external insert port is always present
// --------------------------------------
`timescale 1ns/1ns
`default_nettype none

module route_table_top
  import xb_geom_pkg::*;
  import route_table_pkg::*;
(
  input  wire                           clk,
  input  wire                           reset,
  // Crossbar port inserts
  input  wire  [num_ports-1:0]          port_req_wr,
  input  wire  [num_ports*epid_w-1:0]   port_req_addr,
  input  wire  [num_ports*req_data_w-1:0] port_req_data,
  output wire  [num_ports-1:0]          port_resp_ack,
  // External insert
  input  wire                           ext_req_wr,
  input  wire  [epid_w-1:0]             ext_req_addr,
  input  wire  [req_data_w-1:0]         ext_req_data,
  output wire                           ext_resp_ack,
  // Lookups and answers
  input  wire  [num_ports*epid_w-1:0]   find_tdata,
  input  wire  [num_ports-1:0]          find_tvalid,
  output wire  [num_ports-1:0]          find_tready,
  output wire  [num_ports*port_w-1:0]   result_tdata,
  output wire  [num_ports-1:0]          result_tkeep,
  output wire  [num_ports-1:0]          result_tvalid,
  input  wire  [num_ports-1:0]          result_tready
);

  // Capture outputs packed by source
  wire [cfg_ports-1:0]        held_valid;
  wire [cfg_ports*epid_w-1:0] held_epid;
  wire [cfg_ports*port_w-1:0] held_port;
  wire [cfg_ports-1:0]        src_take;
  // Merged insert stream
  wire                        ins_valid;
  wire                        ins_ready;
  wire [epid_w-1:0]           ins_epid;
  wire [port_w-1:0]           ins_port;
  // Table access
  wire [epid_w-1:0]           match_key;
  wire                        match_hit;
  wire [slot_w-1:0]           match_slot;
  wire [port_w-1:0]           match_port;
  wire                        wr_en;
  wire [slot_w-1:0]           wr_slot;
  wire [epid_w-1:0]           wr_key;
  wire [port_w-1:0]           wr_port;
  wire                        claim;
  wire [slot_w-1:0]           next_slot;
  wire                        full;

  // ------------------------------------
  // Insert capture, one per source
  // ------------------------------------
  for (genvar i = 0; i < num_ports; i++) begin : gen_port_cap
    insert_capture port_cap_i (
      .clk        (clk),
      .reset      (reset),
      .req_wr     (port_req_wr[i]),
      .req_addr   (port_req_addr[i*epid_w +: epid_w]),
      .req_data   (port_req_data[i*req_data_w +: req_data_w]),
      .held_valid (held_valid[i]),
      .held_epid  (held_epid[i*epid_w +: epid_w]),
      .held_port  (held_port[i*port_w +: port_w]),
      .take       (src_take[i]),
      .resp_ack   (port_resp_ack[i])
    );
  end

  // External source takes the last index
  insert_capture ext_cap_i (
    .clk        (clk),
    .reset      (reset),
    .req_wr     (ext_req_wr),
    .req_addr   (ext_req_addr),
    .req_data   (ext_req_data),
    .held_valid (held_valid[num_ports]),
    .held_epid  (held_epid[num_ports*epid_w +: epid_w]),
    .held_port  (held_port[num_ports*port_w +: port_w]),
    .take       (src_take[num_ports]),
    .resp_ack   (ext_resp_ack)
  );

  insert_mux mux_i (
    .clk       (clk),
    .reset     (reset),
    .src_valid (held_valid),
    .src_epid  (held_epid),
    .src_port  (held_port),
    .src_take  (src_take),
    .ins_valid (ins_valid),
    .ins_epid  (ins_epid),
    .ins_port  (ins_port),
    .ins_ready (ins_ready)
  );

  // ------------------------------------
  // Controller, store and fill counter
  // ------------------------------------
  route_fsm fsm_i (
    .clk           (clk),
    .reset         (reset),
    .ins_valid     (ins_valid),
    .ins_epid      (ins_epid),
    .ins_port      (ins_port),
    .ins_ready     (ins_ready),
    .find_tdata    (find_tdata),
    .find_tvalid   (find_tvalid),
    .find_tready   (find_tready),
    .result_tdata  (result_tdata),
    .result_tkeep  (result_tkeep),
    .result_tvalid (result_tvalid),
    .result_tready (result_tready),
    .match_key     (match_key),
    .match_hit     (match_hit),
    .match_slot    (match_slot),
    .match_port    (match_port),
    .wr_en         (wr_en),
    .wr_slot       (wr_slot),
    .wr_key        (wr_key),
    .wr_port       (wr_port),
    .claim         (claim),
    .next_slot     (next_slot),
    .full          (full)
  );

  kv_store store_i (
    .clk        (clk),
    .reset      (reset),
    .match_key  (match_key),
    .match_hit  (match_hit),
    .match_slot (match_slot),
    .match_port (match_port),
    .wr_en      (wr_en),
    .wr_slot    (wr_slot),
    .wr_key     (wr_key),
    .wr_port    (wr_port)
  );

  slot_counter slots_i (
    .clk       (clk),
    .reset     (reset),
    .claim     (claim),
    .next_slot (next_slot),
    .full      (full)
  );

endmodule

`default_nettype wire

//--- source/slot_counter.sv
// --------------------------------------
// Fill count only, entries are never freed
// --------------------------------------
`timescale 1ns/1ns
`default_nettype none

module slot_counter
  import route_table_pkg::*;
(
  input  wire               clk,
  input  wire               reset,
  input  wire               claim,
  output logic [slot_w-1:0] next_slot,
  output logic              full
);

  // One extra bit so the count can reach table_depth
  logic [slot_w:0] fill;

  assign full      = (fill == (slot_w + 1)'(table_depth));
  assign next_slot = fill[slot_w-1:0];

  // Saturates at the table size
  always_ff @(posedge clk) begin
    if (reset) begin
      fill <= '0;
    end else if (claim && !full) begin
      fill <= fill + 1'b1;
    end
  end

  // Controller must drop inserts once the table is full
  no_claim_full: assert property (@(posedge clk) disable iff (reset) claim |-> !full)
    else $error("slot_counter claimed while full");

endmodule

`default_nettype wire

//--- source/xb_geom_pkg.sv
// --------------------------------------
// Geometry fixed at four crossbar ports plus one external insert source
// --------------------------------------
`default_nettype none

package xb_geom_pkg;

  // Crossbar ports and port number width
  localparam int num_ports = 4;
  localparam int port_w    = 2;

  // Endpoint ID and insert request data widths
  localparam int epid_w     = 16;
  localparam int req_data_w = 32;

  // Insert sources, external port sits at the last index
  localparam int cfg_ports = num_ports + 1;
  localparam int cfg_sel_w = $clog2(cfg_ports);

endpackage

`default_nettype wire

//--- verif/tb_route_model.svh
// --------------------------------------
// Expected table in insertion order, valid only once inserts have landed
// --------------------------------------
`ifndef TB_ROUTE_MODEL_SVH
`define TB_ROUTE_MODEL_SVH

// Model entries, filled in ack order
logic [epid_w-1:0] model_key  [table_depth];
logic [port_w-1:0] model_port [table_depth];
int                model_fill = 0;

// Empty table, as after a DUT reset
function automatic void clear_model();
  model_fill = 0;
endfunction

// Overwrite on match, append while space remains, else drop
function automatic void insert_route(input logic [epid_w-1:0] key,
                                     input logic [port_w-1:0] port);
  for (int i = 0; i < model_fill; i++) begin
    if (model_key[i] == key) begin
      model_port[i] = port;
      return;
    end
  end
  if (model_fill < table_depth) begin
    model_key[model_fill]  = key;
    model_port[model_fill] = port;
    model_fill++;
  end
endfunction

// Expected answer as {keep, port}, zero on a miss
function automatic logic [port_w:0] route_lookup(input logic [epid_w-1:0] key);
  for (int i = 0; i < model_fill; i++) begin
    if (model_key[i] == key) begin
      return {1'b1, model_port[i]};
    end
  end
  return '0;
endfunction

// Compare and stop at the first mismatch
task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
  if (expected !== actual) begin
    errors++;
    $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
    $display("Test failures found");
    $fatal(1, "Stopping at the first mismatch");
  end
endtask

`endif

//--- verif/tb_route_table.sv
// --------------------------------------
// Results checked per port in request order, resets clear the table between groups
// --------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_route_table
  import xb_geom_pkg::*;
  import route_table_pkg::*;
();

  // Roughly four times the length of all tests
  localparam int max_cycles = 20000;

  logic                            clk = 1'b0;
  logic                            reset = 1'b1;
  logic [num_ports-1:0]            port_req_wr = '0;
  logic [num_ports*epid_w-1:0]     port_req_addr = '0;
  logic [num_ports*req_data_w-1:0] port_req_data = '0;
  wire  [num_ports-1:0]            port_resp_ack;
  logic                            ext_req_wr = 1'b0;
  logic [epid_w-1:0]               ext_req_addr = '0;
  logic [req_data_w-1:0]           ext_req_data = '0;
  wire                             ext_resp_ack;
  logic [num_ports*epid_w-1:0]     find_tdata = '0;
  logic [num_ports-1:0]            find_tvalid = '0;
  wire  [num_ports-1:0]            find_tready;
  wire  [num_ports*port_w-1:0]     result_tdata;
  wire  [num_ports-1:0]            result_tkeep;
  wire  [num_ports-1:0]            result_tvalid;
  logic [num_ports-1:0]            result_tready = '1;

  // Acks of all sources, external one on top
  wire  [cfg_ports-1:0]            all_acks;

  integer            seed = 62216;
  int                cycles = 0;
  int                errors = 0;
  bit                backpressure = 1'b0;
  string             test_name = "reset";
  int                ack_count [cfg_ports] = '{default: 0};
  int                ack_base  [cfg_ports] = '{default: 0};
  logic [port_w:0]   expect_q  [num_ports][$];
  logic [epid_w-1:0] key_pool  [$];

  `include "tb_route_model.svh"

  assign all_acks = {ext_resp_ack, port_resp_ack};

  route_table_top dut_i (
    .clk           (clk),
    .reset         (reset),
    .port_req_wr   (port_req_wr),
    .port_req_addr (port_req_addr),
    .port_req_data (port_req_data),
    .port_resp_ack (port_resp_ack),
    .ext_req_wr    (ext_req_wr),
    .ext_req_addr  (ext_req_addr),
    .ext_req_data  (ext_req_data),
    .ext_resp_ack  (ext_resp_ack),
    .find_tdata    (find_tdata),
    .find_tvalid   (find_tvalid),
    .find_tready   (find_tready),
    .result_tdata  (result_tdata),
    .result_tkeep  (result_tkeep),
    .result_tvalid (result_tvalid),
    .result_tready (result_tready)
  );

  // 100 ns period
  initial begin
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("Test failures found");
      $fatal(1, "Timeout, tests still running after %0d cycles", max_cycles);
    end
  end

  // Result ready, random only in the back-pressure test
  always @(negedge clk) begin
    if (backpressure) begin
      result_tready = num_ports'($random(seed));
    end else begin
      result_tready = '1;
    end
  end

  // ------------------------------------
  // Comparison and ack counting
  // ------------------------------------
  always @(posedge clk) begin
    logic [port_w:0] got;
    if (!reset) begin
      for (int p = 0; p < num_ports; p++) begin
        // Result first, a find never answers in its own cycle
        if (result_tvalid[p] && result_tready[p]) begin
          got = {result_tkeep[p], result_tdata[p*port_w +: port_w]};
          if (expect_q[p].size() == 0) begin
            $display("Test failures found");
            $fatal(1, "Port %0d returned a result with no find outstanding", p);
          end else begin
            check_value($sformatf("%s port %0d", test_name, p),
                        32'(expect_q[p].pop_front()), 32'(got));
          end
        end
        if (find_tvalid[p] && find_tready[p]) begin
          expect_q[p].push_back(route_lookup(find_tdata[p*epid_w +: epid_w]));
        end
      end
      for (int s = 0; s < cfg_ports; s++) begin
        if (all_acks[s]) begin
          ack_count[s]++;
        end
      end
    end
  end

  // ------------------------------------
  // Stimulus tasks
  // ------------------------------------
  task automatic apply_reset();
    @(negedge clk);
    reset = 1'b1;
    repeat (8) @(negedge clk);
    reset = 1'b0;
    clear_model();
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // One strobe, then wait for the ack of that source
  task automatic send_insert(input int src, input logic [epid_w-1:0] key,
                             input logic [port_w-1:0] port);
    logic [req_data_w-1:0] data;
    // Upper data bits are junk the DUT must ignore
    data = req_data_w'($random(seed));
    data[port_w-1:0] = port;
    @(negedge clk);
    if (src == num_ports) begin
      ext_req_wr   = 1'b1;
      ext_req_addr = key;
      ext_req_data = data;
    end else begin
      port_req_wr[src] = 1'b1;
      port_req_addr[src*epid_w +: epid_w]         = key;
      port_req_data[src*req_data_w +: req_data_w] = data;
    end
    @(negedge clk);
    if (src == num_ports) begin
      ext_req_wr = 1'b0;
    end else begin
      port_req_wr[src] = 1'b0;
    end
    do @(posedge clk); while (!all_acks[src]);
    insert_route(key, port);
  endtask

  task automatic send_find(input int p, input logic [epid_w-1:0] key);
    @(negedge clk);
    find_tvalid[p] = 1'b1;
    find_tdata[p*epid_w +: epid_w] = key;
    do @(posedge clk); while (!find_tready[p]);
    @(negedge clk);
    find_tvalid[p] = 1'b0;
  endtask

  // Walks the key pool in order, or picks at random
  task automatic find_stream(input int p, input int n, input bit shuffle);
    int pick;
    for (int i = 0; i < n; i++) begin
      if (shuffle) begin
        pick = int'($unsigned($random(seed)) % key_pool.size());
      end else begin
        pick = i % key_pool.size();
      end
      send_find(p, key_pool[pick]);
    end
  endtask

  // Drains once every queue is empty and nothing is held
  task automatic wait_results();
    bit busy;
    do begin
      @(negedge clk);
      busy = 1'b0;
      for (int p = 0; p < num_ports; p++) begin
        if (expect_q[p].size() != 0 || result_tvalid[p]) begin
          busy = 1'b1;
        end
      end
    end while (busy);
  endtask

  task automatic all_finds(input int n, input bit shuffle);
    fork
      find_stream(0, n, shuffle);
      find_stream(1, n, shuffle);
      find_stream(2, n, shuffle);
      find_stream(3, n, shuffle);
    join
    wait_results();
  endtask

  task automatic snap_acks();
    for (int s = 0; s < cfg_ports; s++) begin
      ack_base[s] = ack_count[s];
    end
  endtask

  task automatic check_acks(input int n);
    for (int s = 0; s < cfg_ports; s++) begin
      check_value($sformatf("%s acks of source %0d", test_name, s),
                  32'(ack_base[s] + n), 32'(ack_count[s]));
    end
  endtask

  // ------------------------------------
  // Test sequence
  // ------------------------------------
  initial begin
    logic [epid_w-1:0] key;
    apply_reset();

    test_name = "reset state";
    check_value(test_name, 32'd0, 32'(all_acks));
    check_value(test_name, 32'd0, 32'(find_tready));
    check_value(test_name, 32'd0, 32'(result_tvalid));
    test_name = "empty table finds";
    repeat (6) key_pool.push_back(epid_w'($random(seed)));
    all_finds(6, 1'b0);

    test_name = "one insert per source";
    snap_acks();
    key_pool.delete();
    for (int s = 0; s < cfg_ports; s++) begin
      key = epid_w'(16'h1000 + s * 16'h0111);
      key_pool.push_back(key);
      send_insert(s, key, port_w'(s + 1));
    end
    // Let the last insert reach the table
    idle_cycles(6);
    check_acks(1);
    all_finds(cfg_ports, 1'b0);

    test_name = "overwrite";
    snap_acks();
    for (int s = 0; s < cfg_ports; s++) begin
      send_insert((s + 2) % cfg_ports, key_pool[s], port_w'(s + 3));
    end
    idle_cycles(6);
    check_acks(1);
    all_finds(cfg_ports, 1'b0);

    // Four more keys than entries, spread over the sources
    test_name = "table overflow";
    apply_reset();
    snap_acks();
    key_pool.delete();
    for (int i = 0; i < table_depth + 4; i++) begin
      key = epid_w'(16'h2000 + i * 7);
      key_pool.push_back(key);
      send_insert(i % cfg_ports, key, port_w'($random(seed)));
    end
    idle_cycles(6);
    check_acks((table_depth + 4) / cfg_ports);
    all_finds(table_depth + 4, 1'b0);

    // Mix of stored keys and random misses
    test_name = "random finds";
    repeat (8) key_pool.push_back(epid_w'($random(seed)));
    backpressure = 1'b1;
    all_finds(40, 1'b1);
    backpressure = 1'b0;

    test_name = "parallel inserts";
    apply_reset();
    snap_acks();
    key_pool.delete();
    for (int s = 0; s < cfg_ports; s++) begin
      key_pool.push_back({8'(8'h30 + s), 8'($random(seed))});
    end
    fork
      send_insert(0, key_pool[0], 2'd3);
      send_insert(1, key_pool[1], 2'd0);
      send_insert(2, key_pool[2], 2'd1);
      send_insert(3, key_pool[3], 2'd2);
      send_insert(4, key_pool[4], 2'd3);
    join
    idle_cycles(6);
    check_acks(1);
    all_finds(cfg_ports, 1'b0);

    wait_results();
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire
